// File: include/clint_defines.svh
`ifndef CLINT_DEFINES_SVH
`define CLINT_DEFINES_SVH

// bus widths
`define CLINT_ADDR_W 16
`define CLINT_DATA_W 32
`define CLINT_STRB_W 4

// hart count
`define CLINT_NUM_HARTS 2

// clock cycles per mtime increment
`define CLINT_TICK_DIV 4

// address map

// one msip word per hart
`define CLINT_MSIP_BASE 16'h0000

// two words per hart, low word first
`define CLINT_MTIMECMP_BASE 16'h4000

// low word here, high word at +4
`define CLINT_MTIME_BASE 16'hBFF8

`endif

// File: src/axi_lite_slv_clint.sv
`timescale 1ns/1ns
`default_nettype none

`include "clint_defines.svh"

module axi_lite_slv_clint (
    input  wire logic                clk,
    input  wire logic                rst_n,

    // AR
    input  wire clint_pkg::addr_t    araddr,
    input  wire logic                arvalid,
    output logic                     arready,

    // R
    output clint_pkg::data_t         rdata,
    output clint_pkg::resp_t         rresp,
    output logic                     rvalid,
    input  wire logic                rready,

    // AW
    input  wire clint_pkg::addr_t    awaddr,
    input  wire logic                awvalid,
    output logic                     awready,

    // W
    input  wire clint_pkg::data_t    wdata,
    input  wire clint_pkg::strb_t    wstrb,
    input  wire logic                wvalid,
    output logic                     wready,

    // B
    output clint_pkg::resp_t         bresp,
    output logic                     bvalid,
    input  wire logic                bready,

    // register port to the timer and msip blocks
    output clint_pkg::addr_t         reg_addr,
    output clint_pkg::data_t         reg_wdata,
    output clint_pkg::strb_t         reg_wstrb,
    output logic                     timer_we,
    output logic                     swi_we,
    input  wire clint_pkg::data_t    timer_rdata,
    input  wire clint_pkg::data_t    swi_rdata
);

    localparam clint_pkg::addr_t MSIP_FIRST  = `CLINT_MSIP_BASE;
    localparam clint_pkg::addr_t TIMER_FIRST = `CLINT_MTIMECMP_BASE;
    localparam clint_pkg::addr_t TIMER_LAST  = `CLINT_MTIME_BASE + 16'd4;

    clint_pkg::bus_state_e state;
    clint_pkg::bus_state_e next_state;

    clint_pkg::addr_t      addr;
    logic                  sel_msip;
    logic                  sel_timer;
    logic                  we_q;

    // region decode on the latched address
    assign sel_msip  = (addr >= MSIP_FIRST) && (addr < TIMER_FIRST);
    assign sel_timer = (addr >= TIMER_FIRST) && (addr <= TIMER_LAST);

    // a pending read blocks the write address channel
    assign arready = (state == clint_pkg::BUS_IDLE);
    assign awready = (state == clint_pkg::BUS_IDLE) && !arvalid;
    assign wready  = (state == clint_pkg::BUS_AWAIT_W);

    // always OKAY
    assign rresp = '0;
    assign bresp = '0;

    assign reg_addr = addr;
    assign timer_we = we_q && sel_timer;
    assign swi_we   = we_q && sel_msip;

    always_comb begin
        next_state = state;
        case (state)
            clint_pkg::BUS_IDLE: begin
                if (arvalid) begin
                    next_state = clint_pkg::BUS_READ;
                end else if (awvalid) begin
                    next_state = clint_pkg::BUS_AWAIT_W;
                end
            end
            clint_pkg::BUS_READ: begin
                if (rvalid && rready) begin
                    next_state = clint_pkg::BUS_IDLE;
                end
            end
            clint_pkg::BUS_AWAIT_W: begin
                if (wvalid) begin
                    next_state = clint_pkg::BUS_WRESP;
                end
            end
            clint_pkg::BUS_WRESP: begin
                if (bvalid && bready) begin
                    next_state = clint_pkg::BUS_IDLE;
                end
            end
            default: begin
                next_state = clint_pkg::BUS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= clint_pkg::BUS_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // transaction address, read wins over write
    always_ff @(posedge clk) begin
        if (state == clint_pkg::BUS_IDLE) begin
            if (arvalid) begin
                addr <= araddr;
            end else if (awvalid) begin
                addr <= awaddr;
            end
        end
    end

    // read data captured one cycle after AR
    always_ff @(posedge clk) begin
        if (state == clint_pkg::BUS_READ && !rvalid) begin
            if (sel_msip) begin
                rdata <= swi_rdata;
            end else if (sel_timer) begin
                rdata <= timer_rdata;
            end else begin
                rdata <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (state == clint_pkg::BUS_READ && !rvalid) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    // write data held for the one-cycle pulse
    always_ff @(posedge clk) begin
        if (state == clint_pkg::BUS_AWAIT_W && wvalid) begin
            reg_wdata <= wdata;
            reg_wstrb <= wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= (state == clint_pkg::BUS_AWAIT_W) && wvalid;
        end
    end

    // response follows the register update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (state == clint_pkg::BUS_WRESP && !bvalid) begin
            bvalid <= 1'b1;
        end else if (bvalid && bready) begin
            bvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/clint_pkg.sv
`default_nettype none

`include "clint_defines.svh"

package clint_pkg;

    // bus vectors
    typedef logic [`CLINT_ADDR_W-1:0] addr_t;
    typedef logic [`CLINT_DATA_W-1:0] data_t;
    typedef logic [`CLINT_STRB_W-1:0] strb_t;
    typedef logic [1:0] resp_t;

    // machine timer value
    typedef logic [63:0] time_t;

    // one interrupt line per hart
    typedef logic [`CLINT_NUM_HARTS-1:0] hart_mask_t;

    // slave transaction states
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_READ,
        BUS_AWAIT_W,
        BUS_WRESP
    } bus_state_e;

endpackage

`default_nettype wire

// File: src/clint_swi.sv
`timescale 1ns/1ns
`default_nettype none

`include "clint_defines.svh"

module clint_swi (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire clint_pkg::addr_t    reg_addr,
    input  wire clint_pkg::data_t    reg_wdata,
    input  wire clint_pkg::strb_t    reg_wstrb,
    input  wire logic                we,
    output clint_pkg::data_t         rdata,
    output clint_pkg::hart_mask_t    msip
);

    clint_pkg::hart_mask_t hit;

    // one word per hart
    always_comb begin
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            hit[h] = (reg_addr == clint_pkg::addr_t'(`CLINT_MSIP_BASE + 4 * h));
        end
    end

    // only bit 0 of each word is implemented
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msip <= '0;
        end else if (we && reg_wstrb[0]) begin
            for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
                if (hit[h]) begin
                    msip[h] <= reg_wdata[0];
                end
            end
        end
    end

    // harts past the last one read as zero
    always_comb begin
        rdata = '0;
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            if (hit[h]) begin
                rdata[0] = msip[h];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/clint_timer.sv
`timescale 1ns/1ns
`default_nettype none

`include "clint_defines.svh"

module clint_timer (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire clint_pkg::addr_t    reg_addr,
    input  wire clint_pkg::data_t    reg_wdata,
    input  wire clint_pkg::strb_t    reg_wstrb,
    input  wire logic                we,
    output clint_pkg::data_t         rdata,
    output clint_pkg::hart_mask_t    mtip
);

    localparam int PRESC_W = (`CLINT_TICK_DIV > 1) ? $clog2(`CLINT_TICK_DIV) : 1;
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`CLINT_TICK_DIV - 1);

    logic [PRESC_W-1:0]    presc;
    logic                  tick;
    clint_pkg::time_t      mtime;
    clint_pkg::time_t      mtimecmp [`CLINT_NUM_HARTS];

    logic                  mtime_lo_hit;
    logic                  mtime_hi_hit;
    clint_pkg::hart_mask_t cmp_lo_hit;
    clint_pkg::hart_mask_t cmp_hi_hit;

    // replace only the strobed bytes of a word
    function automatic clint_pkg::data_t merge_bytes(
        input clint_pkg::data_t old_word,
        input clint_pkg::data_t new_word,
        input clint_pkg::strb_t strb
    );
        clint_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < `CLINT_STRB_W; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // register decode
    assign mtime_lo_hit = (reg_addr == clint_pkg::addr_t'(`CLINT_MTIME_BASE));
    assign mtime_hi_hit = (reg_addr == clint_pkg::addr_t'(`CLINT_MTIME_BASE + 4));

    always_comb begin
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            cmp_lo_hit[h] = (reg_addr == clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h));
            cmp_hi_hit[h] = (reg_addr == clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h + 4));
        end
    end

    assign tick = (presc == PRESC_LAST);

    // prescaler and mtime, a software write restarts the prescaler
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc <= '0;
            mtime <= '0;
        end else if (we && (mtime_lo_hit || mtime_hi_hit)) begin
            presc <= '0;
            if (mtime_lo_hit) begin
                mtime[31:0] <= merge_bytes(mtime[31:0], reg_wdata, reg_wstrb);
            end
            if (mtime_hi_hit) begin
                mtime[63:32] <= merge_bytes(mtime[63:32], reg_wdata, reg_wstrb);
            end
        end else if (tick) begin
            presc <= '0;
            mtime <= mtime + 64'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // per-hart compare registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
                mtimecmp[h] <= '0;
            end
        end else if (we) begin
            for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
                if (cmp_lo_hit[h]) begin
                    mtimecmp[h][31:0] <= merge_bytes(mtimecmp[h][31:0], reg_wdata, reg_wstrb);
                end
                if (cmp_hi_hit[h]) begin
                    mtimecmp[h][63:32] <= merge_bytes(mtimecmp[h][63:32], reg_wdata, reg_wstrb);
                end
            end
        end
    end

    // timer interrupt, one cycle behind the compare
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtip <= '0;
        end else begin
            for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
                mtip[h] <= (mtime >= mtimecmp[h]);
            end
        end
    end

    // read mux, zero for offsets with no register
    always_comb begin
        rdata = '0;
        if (mtime_lo_hit) begin
            rdata = mtime[31:0];
        end else if (mtime_hi_hit) begin
            rdata = mtime[63:32];
        end
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            if (cmp_lo_hit[h]) begin
                rdata = mtimecmp[h][31:0];
            end
            if (cmp_hi_hit[h]) begin
                rdata = mtimecmp[h][63:32];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/clint_top.sv
`timescale 1ns/1ns
`default_nettype none

module clint_top (
    input  wire logic                clk,
    input  wire logic                rst_n,

    input  wire clint_pkg::addr_t    araddr,
    input  wire logic                arvalid,
    output logic                     arready,

    output clint_pkg::data_t         rdata,
    output clint_pkg::resp_t         rresp,
    output logic                     rvalid,
    input  wire logic                rready,

    input  wire clint_pkg::addr_t    awaddr,
    input  wire logic                awvalid,
    output logic                     awready,

    input  wire clint_pkg::data_t    wdata,
    input  wire clint_pkg::strb_t    wstrb,
    input  wire logic                wvalid,
    output logic                     wready,

    output clint_pkg::resp_t         bresp,
    output logic                     bvalid,
    input  wire logic                bready,

    // interrupt lines, one per hart
    output clint_pkg::hart_mask_t    mtip,
    output clint_pkg::hart_mask_t    msip
);

    clint_pkg::addr_t reg_addr;
    clint_pkg::data_t reg_wdata;
    clint_pkg::strb_t reg_wstrb;
    logic             timer_we;
    logic             swi_we;
    clint_pkg::data_t timer_rdata;
    clint_pkg::data_t swi_rdata;

    axi_lite_slv_clint u_slv (
        .clk         (clk),
        .rst_n       (rst_n),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_wstrb   (reg_wstrb),
        .timer_we    (timer_we),
        .swi_we      (swi_we),
        .timer_rdata (timer_rdata),
        .swi_rdata   (swi_rdata)
    );

    clint_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_wstrb (reg_wstrb),
        .we        (timer_we),
        .rdata     (timer_rdata),
        .mtip      (mtip)
    );

    clint_swi u_swi (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_wstrb (reg_wstrb),
        .we        (swi_we),
        .rdata     (swi_rdata),
        .msip      (msip)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clint.sv
`timescale 1ns/1ns
`default_nettype none

`include "clint_defines.svh"

module tb_clint;

    // about 115 transactions at up to 20 cycles each, plus the mtip waits
    localparam int MAX_CYCLES = 8000;

    logic                  clk = 1'b0;
    logic                  rst_n;
    clint_pkg::addr_t      araddr;
    logic                  arvalid;
    logic                  arready;
    clint_pkg::data_t      rdata;
    clint_pkg::resp_t      rresp;
    logic                  rvalid;
    logic                  rready;
    clint_pkg::addr_t      awaddr;
    logic                  awvalid;
    logic                  awready;
    clint_pkg::data_t      wdata;
    clint_pkg::strb_t      wstrb;
    logic                  wvalid;
    logic                  wready;
    clint_pkg::resp_t      bresp;
    logic                  bvalid;
    logic                  bready;
    clint_pkg::hart_mask_t mtip;
    clint_pkg::hart_mask_t msip;

    integer seed = 32'h81d0;
    int     err_count = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycle_count = 0;

    // reference model state
    clint_pkg::time_t      m_mtime;
    clint_pkg::time_t      m_cmp [`CLINT_NUM_HARTS];
    clint_pkg::hart_mask_t m_msip;
    clint_pkg::hart_mask_t exp_mtip;
    int                    m_presc;
    logic                  pend_we;
    clint_pkg::addr_t      pend_addr;
    clint_pkg::data_t      pend_data;
    clint_pkg::strb_t      pend_strb;
    clint_pkg::addr_t      aw_addr_q;
    clint_pkg::addr_t      ar_addr_q;
    logic                  rd_wait;
    clint_pkg::data_t      exp_rdata;

    clint_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .mtip    (mtip),
        .msip    (msip)
    );

    always #50 clk = ~clk;

    function automatic clint_pkg::data_t apply_strobes(
        input clint_pkg::data_t old_word,
        input clint_pkg::data_t new_word,
        input clint_pkg::strb_t strb
    );
        clint_pkg::data_t mask;
        for (int b = 0; b < `CLINT_STRB_W; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // word the model expects at an address, zero where nothing is mapped
    function automatic clint_pkg::data_t model_word(input clint_pkg::addr_t a);
        clint_pkg::data_t w;
        w = '0;
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            if (a == `CLINT_MSIP_BASE + 4 * h) begin
                w = clint_pkg::data_t'(m_msip[h]);
            end
            if (a == `CLINT_MTIMECMP_BASE + 8 * h) begin
                w = m_cmp[h][31:0];
            end
            if (a == `CLINT_MTIMECMP_BASE + 8 * h + 4) begin
                w = m_cmp[h][63:32];
            end
        end
        if (a == `CLINT_MTIME_BASE) begin
            w = m_mtime[31:0];
        end
        if (a == `CLINT_MTIME_BASE + 4) begin
            w = m_mtime[63:32];
        end
        return w;
    endfunction

    function automatic bit is_mapped(input clint_pkg::addr_t a);
        bit hit;
        hit = (a == `CLINT_MTIME_BASE) || (a == `CLINT_MTIME_BASE + 4);
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            hit |= (a == `CLINT_MSIP_BASE + 4 * h);
            hit |= (a == `CLINT_MTIMECMP_BASE + 8 * h);
            hit |= (a == `CLINT_MTIMECMP_BASE + 8 * h + 4);
        end
        return hit;
    endfunction

    function automatic clint_pkg::addr_t pick_unmapped();
        clint_pkg::addr_t a;
        a = clint_pkg::addr_t'($random(seed)) & 16'hFFFC;
        while (is_mapped(a)) begin
            a = clint_pkg::addr_t'($random(seed)) & 16'hFFFC;
        end
        return a;
    endfunction

    function automatic int random_stall();
        return $unsigned($random(seed)) % 4;
    endfunction

    // model follows the bus transfers, register updates one edge after W
    always @(posedge clk) begin
        if (!rst_n) begin
            m_mtime <= '0;
            m_presc <= 0;
            m_msip <= '0;
            exp_mtip <= '0;
            pend_we <= 1'b0;
            rd_wait <= 1'b0;
            for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
                m_cmp[h] <= '0;
            end
        end else begin
            for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
                exp_mtip[h] <= (m_mtime >= m_cmp[h]);
            end
            if (pend_we && pend_addr == `CLINT_MTIME_BASE) begin
                m_mtime[31:0] <= apply_strobes(m_mtime[31:0], pend_data, pend_strb);
                m_presc <= 0;
            end else if (pend_we && pend_addr == `CLINT_MTIME_BASE + 4) begin
                m_mtime[63:32] <= apply_strobes(m_mtime[63:32], pend_data, pend_strb);
                m_presc <= 0;
            end else if (m_presc == `CLINT_TICK_DIV - 1) begin
                m_mtime <= m_mtime + 64'd1;
                m_presc <= 0;
            end else begin
                m_presc <= m_presc + 1;
            end
            if (pend_we) begin
                for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
                    if (pend_addr == `CLINT_MTIMECMP_BASE + 8 * h) begin
                        m_cmp[h][31:0] <= apply_strobes(m_cmp[h][31:0], pend_data, pend_strb);
                    end
                    if (pend_addr == `CLINT_MTIMECMP_BASE + 8 * h + 4) begin
                        m_cmp[h][63:32] <= apply_strobes(m_cmp[h][63:32], pend_data, pend_strb);
                    end
                    if (pend_addr == `CLINT_MSIP_BASE + 4 * h && pend_strb[0]) begin
                        m_msip[h] <= pend_data[0];
                    end
                end
            end
            if (awvalid && awready) begin
                aw_addr_q <= awaddr;
            end
            pend_we <= wvalid && wready;
            if (wvalid && wready) begin
                pend_addr <= aw_addr_q;
                pend_data <= wdata;
                pend_strb <= wstrb;
            end
            rd_wait <= arvalid && arready;
            if (arvalid && arready) begin
                ar_addr_q <= araddr;
            end
            // data capture edge, one after AR
            if (rd_wait) begin
                exp_rdata <= model_word(ar_addr_q);
            end
        end
    end

    // interrupt lines and responses every cycle
    always @(negedge clk) begin
        if (rst_n) begin
            assert (mtip === exp_mtip) else begin
                err_count++;
                $display("FAIL %0t: mtip %b, expected %b", $time, mtip, exp_mtip);
            end
            assert (msip === m_msip) else begin
                err_count++;
                $display("FAIL %0t: msip %b, expected %b", $time, msip, m_msip);
            end
            assert (rresp === 2'b00 && bresp === 2'b00) else begin
                err_count++;
                $display("FAIL %0t: response rresp %b bresp %b, expected OKAY",
                         $time, rresp, bresp);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_word(input string what, input clint_pkg::data_t got,
                              input clint_pkg::data_t exp);
        assert (got === exp) else begin
            err_count++;
            $display("FAIL %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic read_word(input clint_pkg::addr_t a, output clint_pkg::data_t got);
        int stall;
        stall = random_stall();
        @(posedge clk);
        araddr <= a;
        arvalid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!arready);
        arvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rvalid);
        got = rdata;
        check_word($sformatf("address 0x%04h", a), got, exp_rdata);
        repeat (stall) begin
            @(posedge clk);
            assert (rvalid && rdata === got) else begin
                err_count++;
                $display("FAIL %0t: read response changed before its transfer", $time);
            end
        end
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic write_word(input clint_pkg::addr_t a, input clint_pkg::data_t d,
                              input clint_pkg::strb_t s);
        int stall;
        stall = random_stall();
        @(posedge clk);
        awaddr <= a;
        awvalid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!awready);
        awvalid <= 1'b0;
        wdata <= d;
        wstrb <= s;
        wvalid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!wready);
        wvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!bvalid);
        repeat (stall) begin
            @(posedge clk);
            assert (bvalid) else begin
                err_count++;
                $display("FAIL %0t: bvalid dropped before its transfer", $time);
            end
        end
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic end_test(input string name, input int start_errs);
        if (err_count == start_errs) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - start_errs);
        end
    endtask

    initial begin
        clint_pkg::data_t      got;
        clint_pkg::data_t      wd;
        clint_pkg::strb_t      ws;
        clint_pkg::addr_t      a;
        clint_pkg::time_t      target;
        clint_pkg::time_t      snap_cmp [`CLINT_NUM_HARTS];
        clint_pkg::hart_mask_t snap_msip;
        int                    start;
        int                    idx;
        bit                    seen;

        rst_n <= 1'b0;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b0;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // reset state
        start = err_count;
        @(negedge clk);
        assert (!rvalid && !bvalid && !wready && arready && awready) else begin
            err_count++;
            $display("FAIL %0t: handshake outputs wrong after reset", $time);
        end
        assert (mtip == '0 && msip == '0) else begin
            err_count++;
            $display("FAIL %0t: interrupt lines high after reset", $time);
        end
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            read_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h), got);
            check_word("mtimecmp low after reset", got, '0);
            read_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h + 4), got);
            check_word("mtimecmp high after reset", got, '0);
        end
        end_test("reset state", start);

        // msip with random strobes, indexes past the last hart included
        start = err_count;
        for (int i = 0; i < 24; i++) begin
            idx = $unsigned($random(seed)) % 4;
            wd = $random(seed);
            ws = clint_pkg::strb_t'($random(seed));
            write_word(clint_pkg::addr_t'(`CLINT_MSIP_BASE + 4 * idx), wd, ws);
        end
        for (int i = 0; i < 4; i++) begin
            read_word(clint_pkg::addr_t'(`CLINT_MSIP_BASE + 4 * i), got);
            if (i >= `CLINT_NUM_HARTS) begin
                check_word("msip past last hart", got, '0);
            end else begin
                check_word("msip", got, clint_pkg::data_t'(m_msip[i]));
            end
        end
        end_test("msip", start);

        start = err_count;
        for (int i = 0; i < 24; i++) begin
            idx = $unsigned($random(seed)) % (2 * `CLINT_NUM_HARTS);
            wd = $random(seed);
            ws = clint_pkg::strb_t'($random(seed));
            write_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 4 * idx), wd, ws);
        end
        for (int i = 0; i < 2 * `CLINT_NUM_HARTS; i++) begin
            read_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 4 * i), got);
        end
        end_test("mtimecmp", start);

        // mtime reads are checked against the model at the capture edge
        start = err_count;
        for (int i = 0; i < 4; i++) begin
            wd = $random(seed);
            ws = clint_pkg::strb_t'($random(seed));
            write_word(clint_pkg::addr_t'(`CLINT_MTIME_BASE), wd, ws);
            wd = $random(seed) & 32'h00FF_FFFF;
            write_word(clint_pkg::addr_t'(`CLINT_MTIME_BASE + 4), wd, 4'hF);
            read_word(clint_pkg::addr_t'(`CLINT_MTIME_BASE), got);
            read_word(clint_pkg::addr_t'(`CLINT_MTIME_BASE + 4), got);
        end
        end_test("mtime", start);

        start = err_count;
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            target = m_mtime + clint_pkg::time_t'(10 + $unsigned($random(seed)) % 16);
            write_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h + 4),
                       target[63:32], 4'hF);
            write_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h), target[31:0], 4'hF);
            @(negedge clk);
            assert (!mtip[h]) else begin
                err_count++;
                $display("FAIL %0t: mtip of hart %0d rose before mtime reached mtimecmp",
                         $time, h);
            end
            seen = 1'b0;
            for (int c = 0; c < 200 && !seen; c++) begin
                @(posedge clk);
                seen = mtip[h];
            end
            assert (seen) else begin
                err_count++;
                $display("FAIL %0t: mtip of hart %0d never rose after mtime passed mtimecmp",
                         $time, h);
            end
            write_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h + 4), '1, 4'hF);
            write_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h), '1, 4'hF);
            repeat (2) @(negedge clk);
            assert (!mtip[h]) else begin
                err_count++;
                $display("FAIL %0t: mtip of hart %0d stayed high with mtimecmp at all ones",
                         $time, h);
            end
        end
        end_test("timer interrupts", start);

        // unmapped traffic must leave every register alone
        start = err_count;
        snap_msip = m_msip;
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            snap_cmp[h] = m_cmp[h];
        end
        for (int i = 0; i < 24; i++) begin
            a = pick_unmapped();
            if ($random(seed) & 1) begin
                wd = $random(seed);
                ws = clint_pkg::strb_t'($random(seed));
                write_word(a, wd, ws);
            end else begin
                read_word(a, got);
                check_word("unmapped address", got, '0);
            end
        end
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            read_word(clint_pkg::addr_t'(`CLINT_MSIP_BASE + 4 * h), got);
            check_word("msip after unmapped writes", got, clint_pkg::data_t'(snap_msip[h]));
            read_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h), got);
            check_word("mtimecmp low after unmapped writes", got, snap_cmp[h][31:0]);
            read_word(clint_pkg::addr_t'(`CLINT_MTIMECMP_BASE + 8 * h + 4), got);
            check_word("mtimecmp high after unmapped writes", got, snap_cmp[h][63:32]);
        end
        end_test("handshake and unmapped access", start);

        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
src/clint_pkg.sv
src/axi_lite_slv_clint.sv
src/clint_timer.sv
src/clint_swi.sv
src/clint_top.sv
testbench/tb_clint.sv
